// File: logic/te_reg_macros.svh
// trace encoder config block: widths shared by the package and the RTL
`ifndef TE_REG_MACROS_SVH
`define TE_REG_MACROS_SVH

// architectural width, only the 64-bit variant is built
`define TE_XLEN 64

// privilege level field
`define TE_PRIV_LEN 2

// APB bus
`define TE_APB_ADDR_WIDTH 32
`define TE_APB_DATA_WIDTH 32

// low address bits taken into the register decode
`define TE_REG_OFFSET_WIDTH 8

`endif

// File: logic/te_reg_pkg.sv
// trace encoder config block: register map, trace state and config struct types
`default_nettype none

package te_reg_pkg;

    `include "te_reg_macros.svh"

    // byte offsets of the register map
    typedef enum logic [`TE_REG_OFFSET_WIDTH-1:0] {
        CAUSE_ENABLE_MODE  = 8'h00, // bit 0 enable, bit 1 mode
        TVEC_ENABLE_MODE   = 8'h04,
        PRIV_ENABLE_MODE   = 8'h08,
        IADDR_ENABLE_MODE  = 8'h0C,
        PRIV_RANGE         = 8'h10, // lower in 1:0, upper in 3:2
        PRIV_MATCH         = 8'h14,
        CAUSE_UPPER        = 8'h18,
        CAUSE_LOWER        = 8'h1C,
        CAUSE_MATCH        = 8'h20,
        TVEC_UPPER_L       = 8'h24,
        TVEC_UPPER_M       = 8'h28,
        TVEC_LOWER_L       = 8'h2C,
        TVEC_LOWER_M       = 8'h30,
        TVEC_MATCH_L       = 8'h34,
        TVEC_MATCH_M       = 8'h38,
        IADDR_UPPER_L      = 8'h3C,
        IADDR_UPPER_M      = 8'h40,
        IADDR_LOWER_L      = 8'h44,
        IADDR_LOWER_M      = 8'h48,
        IADDR_MATCH_L      = 8'h4C,
        IADDR_MATCH_M      = 8'h50,
        TRACE_STATE        = 8'h60, // trace_activated
        LOSSLESS_TRACE     = 8'h64,
        SHALLOW_TRACE      = 8'h68,
        NO_TIME            = 8'h6C,
        NO_CONTEXT         = 8'h70,
        DELTA_ADDRESS      = 8'h74,
        FULL_ADDRESS       = 8'h78,
        IMPLICIT_EXCEPTION = 8'h7C,
        SIJUMP             = 8'h80,
        IMPLICIT_RETURN    = 8'h84,
        BRANCH_PREDICTION  = 8'h88,
        JUMP_TARGET_CACHE  = 8'h8C
    } te_reg_addr_e;

    typedef enum logic {
        TRACE_OFF = 1'b0,
        TRACE_ON  = 1'b1
    } trace_state_e;

    // one register access, valid only in the APB access cycle
    typedef struct packed {
        logic                                valid;
        logic                                write;
        logic [`TE_REG_OFFSET_WIDTH-1:0]     offset;
        logic [`TE_APB_DATA_WIDTH-1:0]       wdata;
    } reg_access_s;

    typedef struct packed {
        logic                enable;
        logic                mode; // range or match
        logic [`TE_XLEN-1:0] upper;
        logic [`TE_XLEN-1:0] lower;
        logic [`TE_XLEN-1:0] match;
    } filter_cfg_s;

    typedef struct packed {
        logic                    enable;
        logic                    mode;
        logic [`TE_PRIV_LEN-1:0] upper;
        logic [`TE_PRIV_LEN-1:0] lower;
        logic [`TE_PRIV_LEN-1:0] match;
    } priv_filter_cfg_s;

    // instruction trace options of the packet emitter
    typedef struct packed {
        logic delta_address_en;
        logic full_address_en;
        logic implicit_exception_en;
        logic sijump_en;
        logic implicit_return_en;
        logic branch_prediction_en;
        logic jump_target_cache_en;
    } ioptions_s;

    typedef struct packed {
        logic      trace_activated;
        logic      lossless;  // stall core instead of dropping packets
        logic      shallow;   // flush branch map on every packet
        logic      notime;
        logic      nocontext;
        ioptions_s ioptions;
    } emitter_cfg_s;

endpackage

`default_nettype wire

// File: logic/te_apb_slave.sv
// trace encoder config block: APB slave that turns bus transfers into register accesses
`timescale 1ns/1ps
`default_nettype none

`include "te_reg_macros.svh"

module te_apb_slave
    import te_reg_pkg::*;
(
    input  wire logic                          clk_i,
    input  wire logic                          rst_ni,
    input  wire logic [`TE_APB_ADDR_WIDTH-1:0] paddr_i,
    input  wire logic                          pwrite_i,
    input  wire logic                          psel_i,
    input  wire logic                          penable_i,
    input  wire logic [`TE_APB_DATA_WIDTH-1:0] pwdata_i,
    input  wire logic [`TE_APB_DATA_WIDTH-1:0] filt_rdata_i,
    input  wire logic [`TE_APB_DATA_WIDTH-1:0] emit_rdata_i,
    output logic                               pready_o,
    output logic [`TE_APB_DATA_WIDTH-1:0]      prdata_o,
    output reg_access_s                        access_o
);

    logic setup_q;
    logic access; // access phase right after a setup
    logic read_access;

    // setup phase seen in the previous cycle
    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            setup_q <= 1'b0;
        end else begin
            setup_q <= psel_i && !penable_i;
        end
    end

    assign access      = setup_q && psel_i && penable_i;
    assign read_access = access && !pwrite_i;

    assign pready_o = access; // no wait states

    always_comb begin
        access_o.valid  = access;
        access_o.write  = pwrite_i;
        access_o.offset = paddr_i[`TE_REG_OFFSET_WIDTH-1:0];
        access_o.wdata  = pwdata_i;
    end

    // banks return zero for offsets they do not own, so or-ing is enough
    assign prdata_o = read_access ? (filt_rdata_i | emit_rdata_i) : '0;

endmodule

`default_nettype wire

// File: logic/te_filter_regs.sv
// trace encoder config block: filter registers for cause, trap vector, privilege and address
`timescale 1ns/1ps
`default_nettype none

`include "te_reg_macros.svh"

module te_filter_regs
    import te_reg_pkg::*;
(
    input  wire logic                     clk_i,
    input  wire logic                     rst_ni,
    input  wire reg_access_s              access_i,
    output logic [`TE_APB_DATA_WIDTH-1:0] rdata_o,
    output filter_cfg_s                   cause_cfg_o,
    output filter_cfg_s                   tvec_cfg_o,
    output filter_cfg_s                   iaddr_cfg_o,
    output priv_filter_cfg_s              priv_cfg_o
);

    localparam int unsigned DW = `TE_APB_DATA_WIDTH;
    localparam int unsigned PL = `TE_PRIV_LEN;

    filter_cfg_s      cause_q;
    filter_cfg_s      tvec_q;
    filter_cfg_s      iaddr_q;
    priv_filter_cfg_s priv_q;

    logic          wr_en;
    logic [DW-1:0] wd;

    assign wr_en = access_i.valid && access_i.write;
    assign wd    = access_i.wdata;

    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            cause_q <= '0;
            tvec_q  <= '0;
            iaddr_q <= '0;
            priv_q  <= '0;
        end else if (wr_en) begin
            case (access_i.offset)
                CAUSE_ENABLE_MODE: begin
                    cause_q.enable <= wd[0];
                    cause_q.mode   <= wd[1];
                end
                TVEC_ENABLE_MODE: begin
                    tvec_q.enable <= wd[0];
                    tvec_q.mode   <= wd[1];
                end
                PRIV_ENABLE_MODE: begin
                    priv_q.enable <= wd[0];
                    priv_q.mode   <= wd[1];
                end
                IADDR_ENABLE_MODE: begin
                    iaddr_q.enable <= wd[0];
                    iaddr_q.mode   <= wd[1];
                end
                // lower and upper land together
                PRIV_RANGE: begin
                    priv_q.lower <= wd[PL-1:0];
                    priv_q.upper <= wd[2*PL-1:PL];
                end
                PRIV_MATCH:    priv_q.match <= wd[PL-1:0];
                // cause fits in one bus word, zero-extended
                CAUSE_UPPER:   cause_q.upper <= `TE_XLEN'(wd);
                CAUSE_LOWER:   cause_q.lower <= `TE_XLEN'(wd);
                CAUSE_MATCH:   cause_q.match <= `TE_XLEN'(wd);
                TVEC_UPPER_L:  tvec_q.upper[DW-1:0] <= wd;
                TVEC_UPPER_M:  tvec_q.upper[`TE_XLEN-1:DW] <= wd;
                TVEC_LOWER_L:  tvec_q.lower[DW-1:0] <= wd;
                TVEC_LOWER_M:  tvec_q.lower[`TE_XLEN-1:DW] <= wd;
                TVEC_MATCH_L:  tvec_q.match[DW-1:0] <= wd;
                TVEC_MATCH_M:  tvec_q.match[`TE_XLEN-1:DW] <= wd;
                IADDR_UPPER_L: iaddr_q.upper[DW-1:0] <= wd;
                IADDR_UPPER_M: iaddr_q.upper[`TE_XLEN-1:DW] <= wd;
                IADDR_LOWER_L: iaddr_q.lower[DW-1:0] <= wd;
                IADDR_LOWER_M: iaddr_q.lower[`TE_XLEN-1:DW] <= wd;
                IADDR_MATCH_L: iaddr_q.match[DW-1:0] <= wd;
                IADDR_MATCH_M: iaddr_q.match[`TE_XLEN-1:DW] <= wd;
                default: ; // not a filter register
            endcase
        end
    end

    // read word depends on the offset only, the APB slave qualifies it
    always_comb begin
        rdata_o = '0;
        case (access_i.offset)
            CAUSE_ENABLE_MODE: rdata_o[1:0] = {cause_q.mode, cause_q.enable};
            TVEC_ENABLE_MODE:  rdata_o[1:0] = {tvec_q.mode, tvec_q.enable};
            PRIV_ENABLE_MODE:  rdata_o[1:0] = {priv_q.mode, priv_q.enable};
            IADDR_ENABLE_MODE: rdata_o[1:0] = {iaddr_q.mode, iaddr_q.enable};
            PRIV_RANGE:        rdata_o[2*PL-1:0] = {priv_q.upper, priv_q.lower};
            PRIV_MATCH:        rdata_o[PL-1:0] = priv_q.match;
            CAUSE_UPPER:       rdata_o = cause_q.upper[DW-1:0];
            CAUSE_LOWER:       rdata_o = cause_q.lower[DW-1:0];
            CAUSE_MATCH:       rdata_o = cause_q.match[DW-1:0];
            TVEC_UPPER_L:      rdata_o = tvec_q.upper[DW-1:0];
            TVEC_UPPER_M:      rdata_o = tvec_q.upper[`TE_XLEN-1:DW];
            TVEC_LOWER_L:      rdata_o = tvec_q.lower[DW-1:0];
            TVEC_LOWER_M:      rdata_o = tvec_q.lower[`TE_XLEN-1:DW];
            TVEC_MATCH_L:      rdata_o = tvec_q.match[DW-1:0];
            TVEC_MATCH_M:      rdata_o = tvec_q.match[`TE_XLEN-1:DW];
            IADDR_UPPER_L:     rdata_o = iaddr_q.upper[DW-1:0];
            IADDR_UPPER_M:     rdata_o = iaddr_q.upper[`TE_XLEN-1:DW];
            IADDR_LOWER_L:     rdata_o = iaddr_q.lower[DW-1:0];
            IADDR_LOWER_M:     rdata_o = iaddr_q.lower[`TE_XLEN-1:DW];
            IADDR_MATCH_L:     rdata_o = iaddr_q.match[DW-1:0];
            IADDR_MATCH_M:     rdata_o = iaddr_q.match[`TE_XLEN-1:DW];
            default:           rdata_o = '0;
        endcase
    end

    assign cause_cfg_o = cause_q;
    assign tvec_cfg_o  = tvec_q;
    assign iaddr_cfg_o = iaddr_q;
    assign priv_cfg_o  = priv_q;

endmodule

`default_nettype wire

// File: logic/te_emitter_regs.sv
// trace encoder config block: trace management and packet emitter option registers
`timescale 1ns/1ps
`default_nettype none

`include "te_reg_macros.svh"

module te_emitter_regs
    import te_reg_pkg::*;
(
    input  wire logic                     clk_i,
    input  wire logic                     rst_ni,
    input  wire reg_access_s              access_i,
    output logic [`TE_APB_DATA_WIDTH-1:0] rdata_o,
    output emitter_cfg_s                  cfg_o
);

    emitter_cfg_s cfg_q;
    logic         wr_en;
    logic         wbit; // every register here is a single bit

    assign wr_en = access_i.valid && access_i.write;
    assign wbit  = access_i.wdata[0];

    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            cfg_q                           <= '0;
            cfg_q.trace_activated           <= 1'b1;
            cfg_q.notime                    <= 1'b1;
            cfg_q.nocontext                 <= 1'b1;
            cfg_q.ioptions.delta_address_en <= 1'b1; // the one mandatory option
        end else if (wr_en) begin
            case (access_i.offset)
                TRACE_STATE:        cfg_q.trace_activated <= wbit;
                LOSSLESS_TRACE:     cfg_q.lossless <= wbit;
                SHALLOW_TRACE:      cfg_q.shallow <= wbit;
                NO_TIME:            cfg_q.notime <= wbit;
                NO_CONTEXT:         cfg_q.nocontext <= wbit;
                DELTA_ADDRESS:      cfg_q.ioptions.delta_address_en <= wbit;
                FULL_ADDRESS:       cfg_q.ioptions.full_address_en <= wbit;
                IMPLICIT_EXCEPTION: cfg_q.ioptions.implicit_exception_en <= wbit;
                SIJUMP:             cfg_q.ioptions.sijump_en <= wbit;
                IMPLICIT_RETURN:    cfg_q.ioptions.implicit_return_en <= wbit;
                BRANCH_PREDICTION:  cfg_q.ioptions.branch_prediction_en <= wbit;
                JUMP_TARGET_CACHE:  cfg_q.ioptions.jump_target_cache_en <= wbit;
                default: ;
            endcase
        end
    end

    // readback in bit 0, zero for foreign offsets
    always_comb begin
        rdata_o = '0;
        case (access_i.offset)
            TRACE_STATE:        rdata_o[0] = cfg_q.trace_activated;
            LOSSLESS_TRACE:     rdata_o[0] = cfg_q.lossless;
            SHALLOW_TRACE:      rdata_o[0] = cfg_q.shallow;
            NO_TIME:            rdata_o[0] = cfg_q.notime;
            NO_CONTEXT:         rdata_o[0] = cfg_q.nocontext;
            DELTA_ADDRESS:      rdata_o[0] = cfg_q.ioptions.delta_address_en;
            FULL_ADDRESS:       rdata_o[0] = cfg_q.ioptions.full_address_en;
            IMPLICIT_EXCEPTION: rdata_o[0] = cfg_q.ioptions.implicit_exception_en;
            SIJUMP:             rdata_o[0] = cfg_q.ioptions.sijump_en;
            IMPLICIT_RETURN:    rdata_o[0] = cfg_q.ioptions.implicit_return_en;
            BRANCH_PREDICTION:  rdata_o[0] = cfg_q.ioptions.branch_prediction_en;
            JUMP_TARGET_CACHE:  rdata_o[0] = cfg_q.ioptions.jump_target_cache_en;
            default:            rdata_o = '0;
        endcase
    end

    assign cfg_o = cfg_q;

endmodule

`default_nettype wire

// File: logic/te_trace_ctrl.sv
// trace encoder config block: trace on/off toggle driven by request rising edges
`timescale 1ns/1ps
`default_nettype none

module te_trace_ctrl
    import te_reg_pkg::*;
(
    input  wire logic clk_i,
    input  wire logic rst_ni,
    input  wire logic trace_activated_i,
    input  wire logic trace_req_on_i,
    input  wire logic trace_req_off_i,
    output logic      trace_enable_o
);

    logic         req_on_q;
    logic         req_off_q;
    logic         rise_on;
    logic         rise_off;
    trace_state_e state_q;
    trace_state_e state_d;

    // edge registers only sample while activated
    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            req_on_q  <= 1'b0;
            req_off_q <= 1'b0;
        end else if (trace_activated_i) begin
            req_on_q  <= trace_req_on_i;
            req_off_q <= trace_req_off_i;
        end
    end

    assign rise_on  = trace_activated_i && trace_req_on_i && !req_on_q;
    assign rise_off = trace_activated_i && trace_req_off_i && !req_off_q;

    // on only from off, off only from on
    always_comb begin
        state_d = state_q;
        if (state_q == TRACE_OFF && rise_on) begin
            state_d = TRACE_ON;
        end else if (state_q == TRACE_ON && rise_off) begin
            state_d = TRACE_OFF;
        end
    end

    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            state_q <= TRACE_OFF;
        end else begin
            state_q <= state_d;
        end
    end

    assign trace_enable_o = (state_d == TRACE_ON); // takes effect in the edge cycle

endmodule

`default_nettype wire

// File: logic/te_reg_top.sv
// trace encoder config block: top level with APB slave, register banks and trace control
`timescale 1ns/1ps
`default_nettype none

`include "te_reg_macros.svh"

module te_reg_top
    import te_reg_pkg::*;
(
    input  wire logic                          clk_i,
    input  wire logic                          rst_ni,
    // APB
    input  wire logic [`TE_APB_ADDR_WIDTH-1:0] paddr_i,
    input  wire logic                          pwrite_i,
    input  wire logic                          psel_i,
    input  wire logic                          penable_i,
    input  wire logic [`TE_APB_DATA_WIDTH-1:0] pwdata_i,
    output logic                               pready_o,
    output logic [`TE_APB_DATA_WIDTH-1:0]      prdata_o,
    // trace requests
    input  wire logic                          trace_req_on_i,
    input  wire logic                          trace_req_off_i,
    // configuration
    output filter_cfg_s                        cause_cfg_o,
    output filter_cfg_s                        tvec_cfg_o,
    output filter_cfg_s                        iaddr_cfg_o,
    output priv_filter_cfg_s                   priv_cfg_o,
    output emitter_cfg_s                       emitter_cfg_o,
    output logic                               trace_enable_o
);

    reg_access_s                   access;
    logic [`TE_APB_DATA_WIDTH-1:0] filt_rdata;
    logic [`TE_APB_DATA_WIDTH-1:0] emit_rdata;

    te_apb_slave i_apb_slave (
        .clk_i        (clk_i),
        .rst_ni       (rst_ni),
        .paddr_i      (paddr_i),
        .pwrite_i     (pwrite_i),
        .psel_i       (psel_i),
        .penable_i    (penable_i),
        .pwdata_i     (pwdata_i),
        .filt_rdata_i (filt_rdata),
        .emit_rdata_i (emit_rdata),
        .pready_o     (pready_o),
        .prdata_o     (prdata_o),
        .access_o     (access)
    );

    te_filter_regs i_filter_regs (
        .clk_i       (clk_i),
        .rst_ni      (rst_ni),
        .access_i    (access),
        .rdata_o     (filt_rdata),
        .cause_cfg_o (cause_cfg_o),
        .tvec_cfg_o  (tvec_cfg_o),
        .iaddr_cfg_o (iaddr_cfg_o),
        .priv_cfg_o  (priv_cfg_o)
    );

    te_emitter_regs i_emitter_regs (
        .clk_i    (clk_i),
        .rst_ni   (rst_ni),
        .access_i (access),
        .rdata_o  (emit_rdata),
        .cfg_o    (emitter_cfg_o)
    );

    te_trace_ctrl i_trace_ctrl (
        .clk_i             (clk_i),
        .rst_ni            (rst_ni),
        .trace_activated_i (emitter_cfg_o.trace_activated),
        .trace_req_on_i    (trace_req_on_i),
        .trace_req_off_i   (trace_req_off_i),
        .trace_enable_o    (trace_enable_o)
    );

endmodule

`default_nettype wire

// File: test/te_reg_assert.sv
// concurrent checks on APB response and trace state changes in the trace encoder config block
`timescale 1ns/1ps
`default_nettype none

`include "te_reg_macros.svh"

module te_reg_assert (
    input wire logic                          clk_i,
    input wire logic                          rst_ni,
    input wire logic                          psel_i,
    input wire logic                          penable_i,
    input wire logic                          pwrite_i,
    input wire logic                          pready_i,
    input wire logic [`TE_APB_DATA_WIDTH-1:0] prdata_i,
    input wire logic                          req_edge_i,
    input wire logic                          state_i
);

    logic        req_edge_q; // request edge seen in the previous cycle
    int unsigned fail_count = 0; // failed assertions so far

    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            req_edge_q <= 1'b0;
        end else begin
            req_edge_q <= req_edge_i;
        end
    end

    // ready only in an access phase that follows a setup
    pready_in_access: assert property (@(posedge clk_i) disable iff (!rst_ni)
        pready_i |-> (psel_i && penable_i && $past(psel_i && !penable_i)))
        else begin
            $error("pready_o high outside an access phase");
            fail_count++;
        end

    // read access taken from the bus itself
    prdata_zero_when_idle: assert property (@(posedge clk_i) disable iff (!rst_ni)
        !(psel_i && penable_i && !pwrite_i && $past(psel_i && !penable_i))
            |-> (prdata_i == '0))
        else begin
            $error("prdata_o not zero outside a read access");
            fail_count++;
        end

    // state moves only one cycle after an on or off edge
    state_after_edge: assert property (@(posedge clk_i) disable iff (!rst_ni)
        $changed(state_i) |-> req_edge_q)
        else begin
            $error("trace state changed without a request edge");
            fail_count++;
        end

endmodule

`default_nettype wire

// File: test/te_reg_tb.sv
// directed testbench for APB register access and trace toggle of the trace encoder config block
`timescale 1ns/1ps
`default_nettype none

`include "te_reg_macros.svh"

module te_reg_tb
    import te_reg_pkg::*;
();

    localparam int TIMEOUT_CYCLES = 20;

    logic                          clk;
    logic                          rst_n;
    logic [`TE_APB_ADDR_WIDTH-1:0] paddr;
    logic                          pwrite;
    logic                          psel;
    logic                          penable;
    logic [`TE_APB_DATA_WIDTH-1:0] pwdata;
    logic                          pready;
    logic [`TE_APB_DATA_WIDTH-1:0] prdata;
    logic                          trace_req_on;
    logic                          trace_req_off;
    filter_cfg_s                   cause_cfg;
    filter_cfg_s                   tvec_cfg;
    filter_cfg_s                   iaddr_cfg;
    priv_filter_cfg_s              priv_cfg;
    emitter_cfg_s                  emitter_cfg;
    logic                          trace_enable;

    // expected configuration kept by the tests
    filter_cfg_s      exp_cause;
    filter_cfg_s      exp_tvec;
    filter_cfg_s      exp_iaddr;
    priv_filter_cfg_s exp_priv;
    emitter_cfg_s     exp_emit;

    int total_checks;
    int total_errors;
    int test_checks;
    int test_errors;

    te_reg_top DUT (
        .clk_i           (clk),
        .rst_ni          (rst_n),
        .paddr_i         (paddr),
        .pwrite_i        (pwrite),
        .psel_i          (psel),
        .penable_i       (penable),
        .pwdata_i        (pwdata),
        .pready_o        (pready),
        .prdata_o        (prdata),
        .trace_req_on_i  (trace_req_on),
        .trace_req_off_i (trace_req_off),
        .cause_cfg_o     (cause_cfg),
        .tvec_cfg_o      (tvec_cfg),
        .iaddr_cfg_o     (iaddr_cfg),
        .priv_cfg_o      (priv_cfg),
        .emitter_cfg_o   (emitter_cfg),
        .trace_enable_o  (trace_enable)
    );

    // checks that do not apply to a target see tied-off inputs
    bind te_apb_slave te_reg_assert i_apb_assert (
        .clk_i (clk_i), .rst_ni (rst_ni), .psel_i (psel_i), .penable_i (penable_i),
        .pwrite_i (pwrite_i), .pready_i (pready_o), .prdata_i (prdata_o),
        .req_edge_i (1'b0), .state_i (1'b0)
    );

    bind te_trace_ctrl te_reg_assert i_trace_assert (
        .clk_i (clk_i), .rst_ni (rst_ni), .psel_i (1'b0), .penable_i (1'b0),
        .pwrite_i (1'b0), .pready_i (1'b0), .prdata_i ('0),
        .req_edge_i (rise_on || rise_off), .state_i (state_q)
    );

    always #2 clk = ~clk;

    task automatic check_value(input string name, input logic [255:0] got,
                               input logic [255:0] exp);
        test_checks++;
        assert (got === exp) else begin
            $display("CHECK FAILED at time %0t: %s is %0h, expected %0h", $time, name, got, exp);
            test_errors++;
        end
    endtask

    // setup then access with the result sampled mid-cycle before the closing edge
    task automatic apb_transfer(input logic write, input logic [7:0] offset,
                                input logic [31:0] wdata, output logic [31:0] rdata);
        int waited;
        waited = 0;
        @(negedge clk);
        paddr   = {24'h0, offset};
        pwrite  = write;
        pwdata  = wdata;
        psel    = 1'b1;
        penable = 1'b0;
        @(negedge clk);
        penable = 1'b1;
        #1;
        while (!pready && waited < TIMEOUT_CYCLES) begin
            @(negedge clk);
            #1;
            waited++;
        end
        rdata = prdata;
        if (!pready) begin
            $display("no pready from the DUT within %0d cycles at offset %02h",
                     TIMEOUT_CYCLES, offset);
            test_errors++;
        end
        @(negedge clk);
        psel    = 1'b0;
        penable = 1'b0;
        pwrite  = 1'b0;
    endtask

    task automatic apb_write(input logic [7:0] offset, input logic [31:0] wdata);
        logic [31:0] unused;
        apb_transfer(1'b1, offset, wdata, unused);
    endtask

    task automatic read_check(input logic [7:0] offset, input logic [31:0] exp);
        logic [31:0] rd;
        apb_transfer(1'b0, offset, 32'h0, rd);
        check_value($sformatf("prdata_o at %02h", offset), 256'(rd), 256'(exp));
    endtask

    task automatic check_outputs();
        check_value("cause_cfg_o", 256'(cause_cfg), 256'(exp_cause));
        check_value("tvec_cfg_o", 256'(tvec_cfg), 256'(exp_tvec));
        check_value("iaddr_cfg_o", 256'(iaddr_cfg), 256'(exp_iaddr));
        check_value("priv_cfg_o", 256'(priv_cfg), 256'(exp_priv));
        check_value("emitter_cfg_o", 256'(emitter_cfg), 256'(exp_emit));
    endtask

    // one request cycle with enable checked in the same cycle
    task automatic drive_req(input logic on, input logic off, input logic exp);
        @(negedge clk);
        trace_req_on  = on;
        trace_req_off = off;
        #1;
        check_value("trace_enable_o", 256'(trace_enable), 256'(exp));
    endtask

    task automatic start_test();
        test_checks = 0;
        test_errors = 0;
    endtask

    task automatic finish_test(input string name);
        $display("test %-10s %0d checks, %0d errors", name, test_checks, test_errors);
        total_checks += test_checks;
        total_errors += test_errors;
    endtask

    function automatic logic [31:0] reset_word(input te_reg_addr_e a);
        case (a)
            TRACE_STATE, NO_TIME, NO_CONTEXT, DELTA_ADDRESS: return 32'h1;
            default: return 32'h0;
        endcase
    endfunction

    // bits kept by the filter registers at 0x00 to 0x50
    function automatic logic [31:0] filter_mask(input int idx);
        if (idx < 4 || idx == 5) return 32'h3;
        if (idx == 4) return 32'hf;
        return 32'hffff_ffff;
    endfunction

    task automatic test_reset_defaults();
        te_reg_addr_e a;
        start_test();
        exp_cause = '0;
        exp_tvec  = '0;
        exp_iaddr = '0;
        exp_priv  = '0;
        exp_emit  = '0;
        exp_emit.trace_activated           = 1'b1;
        exp_emit.notime                    = 1'b1;
        exp_emit.nocontext                 = 1'b1;
        exp_emit.ioptions.delta_address_en = 1'b1;
        a = a.first();
        for (int n = 0; n < a.num(); n++) begin
            read_check(a, reset_word(a));
            a = a.next();
        end
        check_outputs();
        check_value("trace_enable_o", 256'(trace_enable), 256'(1'b0));
        finish_test("reset");
    endtask

    task automatic test_filter_regs();
        logic [31:0] w [21];
        start_test();
        for (int i = 0; i < 21; i++) begin
            w[i] = $urandom;
            apb_write(8'(i * 4), w[i]);
        end
        for (int i = 0; i < 21; i++) begin
            read_check(8'(i * 4), w[i] & filter_mask(i));
        end
        exp_cause.enable = w[0][0];
        exp_cause.mode   = w[0][1];
        exp_cause.upper  = {32'h0, w[6]}; // zero-extended
        exp_cause.lower  = {32'h0, w[7]};
        exp_cause.match  = {32'h0, w[8]};
        exp_tvec.enable  = w[1][0];
        exp_tvec.mode    = w[1][1];
        exp_tvec.upper   = {w[10], w[9]};
        exp_tvec.lower   = {w[12], w[11]};
        exp_tvec.match   = {w[14], w[13]};
        exp_priv.enable  = w[2][0];
        exp_priv.mode    = w[2][1];
        exp_priv.lower   = w[4][1:0];
        exp_priv.upper   = w[4][3:2];
        exp_priv.match   = w[5][1:0];
        exp_iaddr.enable = w[3][0];
        exp_iaddr.mode   = w[3][1];
        exp_iaddr.upper  = {w[16], w[15]};
        exp_iaddr.lower  = {w[18], w[17]};
        exp_iaddr.match  = {w[20], w[19]};
        check_outputs();
        finish_test("filter");
    endtask

    task automatic test_emitter_regs();
        logic [11:0] bits; // msb is TRACE_STATE and the rest follow offset order
        logic [31:0] wd;
        start_test();
        bits = 12'($urandom);
        for (int pass = 0; pass < 2; pass++) begin
            if (pass == 1) begin
                bits = ~bits; // every bit flips once
            end
            for (int i = 0; i < 12; i++) begin
                wd    = $urandom;
                wd[0] = bits[11 - i];
                apb_write(8'(32'h60 + 4 * i), wd);
            end
            for (int i = 0; i < 12; i++) begin
                read_check(8'(32'h60 + 4 * i), {31'h0, bits[11 - i]});
            end
            exp_emit = emitter_cfg_s'(bits);
            check_outputs();
        end
        apb_write(TRACE_STATE, 32'h1);
        exp_emit.trace_activated = 1'b1;
        check_outputs();
        finish_test("emitter");
    endtask

    task automatic test_unmapped();
        logic [7:0] holes [6];
        start_test();
        holes = '{8'h54, 8'h58, 8'h5C, 8'h90, 8'hA0, 8'hFC};
        foreach (holes[i]) begin
            apb_write(holes[i], $urandom);
            read_check(holes[i], 32'h0);
        end
        check_outputs();
        check_value("trace_enable_o", 256'(trace_enable), 256'(1'b0));
        finish_test("unmapped");
    endtask

    task automatic test_trace_toggle();
        start_test();
        drive_req(1'b0, 1'b0, 1'b0);
        drive_req(1'b1, 1'b0, 1'b1); // on edge
        repeat (3) drive_req(1'b1, 1'b0, 1'b1);
        drive_req(1'b0, 1'b0, 1'b1);
        drive_req(1'b0, 1'b1, 1'b0); // off edge
        drive_req(1'b0, 1'b1, 1'b0);
        drive_req(1'b0, 1'b0, 1'b0);
        drive_req(1'b0, 1'b1, 1'b0); // off while off
        drive_req(1'b0, 1'b0, 1'b0);
        drive_req(1'b1, 1'b0, 1'b1);
        drive_req(1'b0, 1'b0, 1'b1);
        drive_req(1'b1, 1'b0, 1'b1); // on while on
        drive_req(1'b0, 1'b0, 1'b1);
        drive_req(1'b0, 1'b1, 1'b0);
        drive_req(1'b0, 1'b0, 1'b0);
        finish_test("toggle");
    endtask

    task automatic test_deactivation();
        start_test();
        apb_write(TRACE_STATE, 32'h0);
        exp_emit.trace_activated = 1'b0;
        check_outputs();
        drive_req(1'b1, 1'b0, 1'b0); // ignored
        drive_req(1'b0, 1'b0, 1'b0);
        drive_req(1'b1, 1'b0, 1'b0);
        drive_req(1'b0, 1'b0, 1'b0);
        apb_write(TRACE_STATE, 32'h1);
        exp_emit.trace_activated = 1'b1;
        check_outputs();
        drive_req(1'b1, 1'b0, 1'b1); // fresh edge
        drive_req(1'b0, 1'b0, 1'b1);
        apb_write(TRACE_STATE, 32'h0);
        drive_req(1'b0, 1'b1, 1'b1); // off ignored too
        drive_req(1'b0, 1'b0, 1'b1);
        apb_write(TRACE_STATE, 32'h1);
        drive_req(1'b0, 1'b1, 1'b0);
        drive_req(1'b0, 1'b0, 1'b0);
        check_outputs();
        finish_test("deactivate");
    endtask

    initial begin
        void'($urandom(32'hdbd6));
        clk           = 1'b0;
        rst_n         = 1'b0;
        paddr         = '0;
        pwrite        = 1'b0;
        psel          = 1'b0;
        penable       = 1'b0;
        pwdata        = '0;
        trace_req_on  = 1'b0;
        trace_req_off = 1'b0;
        total_checks  = 0;
        total_errors  = 0;
        repeat (16) @(negedge clk);
        rst_n = 1'b1;
        test_reset_defaults();
        test_filter_regs();
        test_emitter_regs();
        test_unmapped();
        test_trace_toggle();
        test_deactivation();
        total_errors += int'(DUT.i_apb_slave.i_apb_assert.fail_count);
        total_errors += int'(DUT.i_trace_ctrl.i_trace_assert.fail_count);
        $display("summary: %0d checks, %0d errors", total_checks, total_errors);
        if (total_errors == 0) begin
            $display("ALL CHECKS PASSED");
        end else begin
            $display("CHECKS FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: sim.f
+incdir+logic
logic/te_reg_pkg.sv
logic/te_apb_slave.sv
logic/te_filter_regs.sv
logic/te_emitter_regs.sv
logic/te_trace_ctrl.sv
logic/te_reg_top.sv
test/te_reg_assert.sv
test/te_reg_tb.sv

// File: run.sh
#!/bin/sh
# build and run the trace encoder config block testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -f sim.f --top-module te_reg_tb -o te_reg_sim

./obj_dir/te_reg_sim | tee sim.log

if grep -qx "ALL CHECKS PASSED" sim.log; then
    exit 0
fi
exit 1
